// ==== Bender.yml ====
package:
  name: item_map

sources:
  - files:
      - hw/itemMapPkg.sv
      - hw/itemRandom.sv
      - hw/itemPlacer.sv
      - hw/itemTable.sv
      - hw/itemMap.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tbClockGen.sv
      - verification/itemMapTb.sv

// ==== hw/itemMap.sv ====
`timescale 1ns/1ns

// item map top: generator, placer and record table
module itemMap (
    input  logic clock,
    input  logic resetn,
    input  logic generateStart,
    input  logic [itemMapPkg::quantityW-1:0] stoneCount,
    input  logic [itemMapPkg::quantityW-1:0] goldCount,
    input  logic [itemMapPkg::quantityW-1:0] diamondCount,
    input  logic moveEnableA,
    input  logic movedA,
    input  logic visibleA,
    input  logic [itemMapPkg::indexW-1:0] moveIndexA,
    input  logic signed [itemMapPkg::deltaW-1:0] deltaXA,
    input  logic signed [itemMapPkg::deltaW-1:0] deltaYA,
    input  logic moveEnableB,
    input  logic movedB,
    input  logic visibleB,
    input  logic [itemMapPkg::indexW-1:0] moveIndexB,
    input  logic signed [itemMapPkg::deltaW-1:0] deltaXB,
    input  logic signed [itemMapPkg::deltaW-1:0] deltaYB,
    output logic busy,
    output logic [itemMapPkg::countW-1:0] itemCount,
    output itemMapPkg::itemRecordT items [itemMapPkg::maxItems]
);

    // generator handshake
    logic randomEnable;
    logic [itemMapPkg::randW-1:0] randomValue;

    // placer writes into the table
    logic tableClear;
    logic placeEnable;
    logic [itemMapPkg::indexW-1:0] placeIndex;
    itemMapPkg::itemRecordT placeRecord;

    itemRandom itemRandom_i (
        .clock(clock),
        .resetn(resetn),
        .randomEnable(randomEnable),
        .randomValue(randomValue)
    );

    itemPlacer itemPlacer_i (
        .clock(clock),
        .resetn(resetn),
        .generateStart(generateStart),
        .stoneCount(stoneCount),
        .goldCount(goldCount),
        .diamondCount(diamondCount),
        .randomValue(randomValue),
        .items(items),
        .randomEnable(randomEnable),
        .tableClear(tableClear),
        .placeEnable(placeEnable),
        .busy(busy),
        .placeIndex(placeIndex),
        .placeRecord(placeRecord),
        .itemCount(itemCount)
    );

    // busy also blocks the move ports
    itemTable itemTable_i (
        .clock(clock),
        .resetn(resetn),
        .tableClear(tableClear),
        .placeEnable(placeEnable),
        .busy(busy),
        .placeIndex(placeIndex),
        .placeRecord(placeRecord),
        .moveEnableA(moveEnableA),
        .movedA(movedA),
        .visibleA(visibleA),
        .moveIndexA(moveIndexA),
        .deltaXA(deltaXA),
        .deltaYA(deltaYA),
        .moveEnableB(moveEnableB),
        .movedB(movedB),
        .visibleB(visibleB),
        .moveIndexB(moveIndexB),
        .deltaXB(deltaXB),
        .deltaYB(deltaYB),
        .items(items)
    );

endmodule

// ==== hw/itemMapPkg.sv ====
package itemMapPkg;

    // item table capacity
    localparam int maxItems = 8;
    localparam int indexW = 3;
    // count runs 0..maxItems so one extra bit
    localparam int countW = 4;
    // requested amount per kind
    localparam int quantityW = 4;

    // playfield in cells
    localparam int gridCols = 20;
    localparam int gridRows = 10;
    // 256 sub-pixel units per cell
    localparam int cellShift = 8;

    // sub-pixel position fields
    localparam int posXW = 13;
    localparam int posYW = 12;
    // signed move step
    localparam int deltaW = 11;

    // generator: next = (randMulA * value + randAddB) mod 2**randW
    localparam int randW = 9;
    localparam int randSeed = 173;
    localparam int randMulA = 43;
    localparam int randAddB = 181;

    // unused record bits, kept at zero
    localparam int spareW = 32 - posXW - posYW - 4;

    // placement order is stones, gold, then diamonds
    typedef enum logic [1:0] {
        kindStone = 2'd0,
        kindGold = 2'd1,
        kindDiamond = 2'd2
    } itemKindT;

    // one 32-bit item record, position in the upper bits
    typedef struct packed {
        logic [posXW-1:0] posX;
        logic [posYW-1:0] posY;
        logic [spareW-1:0] spare;
        itemKindT kind;
        logic visible;
        logic moved;
    } itemRecordT;

endpackage

// ==== hw/itemPlacer.sv ====
`timescale 1ns/1ns

// generation FSM: clear table, draw a cell, scan earlier items, save
module itemPlacer (
    input  logic clock,
    input  logic resetn,
    input  logic generateStart,
    input  logic [itemMapPkg::quantityW-1:0] stoneCount,
    input  logic [itemMapPkg::quantityW-1:0] goldCount,
    input  logic [itemMapPkg::quantityW-1:0] diamondCount,
    input  logic [itemMapPkg::randW-1:0] randomValue,
    input  itemMapPkg::itemRecordT items [itemMapPkg::maxItems],
    output logic randomEnable,
    output logic tableClear,
    output logic placeEnable,
    output logic busy,
    output logic [itemMapPkg::indexW-1:0] placeIndex,
    output itemMapPkg::itemRecordT placeRecord,
    output logic [itemMapPkg::countW-1:0] itemCount
);

    typedef enum logic [2:0] {
        stateIdle,
        stateClear,
        stateDraw,
        stateCheck,
        stateSave
    } stateT;

    stateT state;

    // request latched when generation starts
    logic [itemMapPkg::countW-1:0] targetCount;
    logic [itemMapPkg::quantityW:0] stoneLimit;
    logic [itemMapPkg::quantityW:0] goldLimit;
    logic [itemMapPkg::quantityW+1:0] requestSum;

    // candidate under test
    logic [itemMapPkg::posXW-1:0] candX;
    logic [itemMapPkg::posYW-1:0] candY;
    itemMapPkg::itemKindT candKind;
    logic [itemMapPkg::indexW-1:0] checkIndex;
    logic candHit;
    logic lastCheck;
    // some earlier item already sits on the candidate cell
    logic candTaken;

    // random value split into 5-bit x and 4-bit y
    logic [4:0] randX;
    logic [3:0] randY;
    logic [4:0] cellCol;
    logic [3:0] cellRow;

    assign randX = randomValue[itemMapPkg::randW-1:4];
    assign randY = randomValue[3:0];

    // fold 0..31 onto columns 1..20 and 0..15 onto rows 1..10
    assign cellCol = (randX >= 5'(itemMapPkg::gridCols))
        ? 5'(2 * itemMapPkg::gridCols - 1 - randX)
        : 5'(itemMapPkg::gridCols - randX);
    assign cellRow = (randY >= 4'(itemMapPkg::gridRows))
        ? 4'(2 * itemMapPkg::gridRows - 1 - randY)
        : 4'(itemMapPkg::gridRows - randY);

    assign requestSum = stoneCount + goldCount + diamondCount;

    // one earlier item compared per cycle
    assign candHit = (items[checkIndex].posX == candX) && (items[checkIndex].posY == candY);
    assign lastCheck = (itemMapPkg::countW'(checkIndex) + 1'b1) == itemCount;

    // kind follows position in the order
    assign candKind = (itemCount < stoneLimit) ? itemMapPkg::kindStone
                    : (itemCount < goldLimit) ? itemMapPkg::kindGold
                    : itemMapPkg::kindDiamond;

    assign busy = (state != stateIdle);
    assign tableClear = (state == stateClear);
    assign randomEnable = (state == stateDraw);
    assign placeEnable = (state == stateSave);
    assign placeIndex = itemCount[itemMapPkg::indexW-1:0];

    always_comb begin
        placeRecord = '0;
        placeRecord.posX = candX;
        placeRecord.posY = candY;
        placeRecord.kind = candKind;
        // fresh item is shown and not yet moved
        placeRecord.visible = 1'b1;
        placeRecord.moved = 1'b0;
    end

    // all earlier items at once, against the serial scan
    always_comb begin
        candTaken = 1'b0;
        for (int i = 0; i < itemMapPkg::maxItems; i++) begin
            if (i < itemCount && items[i].posX == candX && items[i].posY == candY) begin
                candTaken = 1'b1;
            end
        end
    end

    // control
    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= stateIdle;
            itemCount <= '0;
            checkIndex <= '0;
        end else begin
            case (state)
                stateIdle: begin
                    if (generateStart) begin
                        state <= stateClear;
                    end
                end
                stateClear: begin
                    itemCount <= '0;
                    // nothing requested, done at once
                    state <= (requestSum == '0) ? stateIdle : stateDraw;
                end
                stateDraw: begin
                    checkIndex <= '0;
                    // first item has nothing to collide with
                    state <= (itemCount == '0) ? stateSave : stateCheck;
                end
                stateCheck: begin
                    checkIndex <= checkIndex + 1'b1;
                    if (candHit) begin
                        state <= stateDraw;
                    end else if (lastCheck) begin
                        state <= stateSave;
                    end
                end
                stateSave: begin
                    itemCount <= itemCount + 1'b1;
                    state <= (itemCount + 1'b1 >= targetCount) ? stateIdle : stateDraw;
                end
                default: begin
                    state <= stateIdle;
                end
            endcase
        end
    end

    // request and candidate
    always_ff @(posedge clock) begin
        if (state == stateClear) begin
            // cap total at table size
            targetCount <= (requestSum > itemMapPkg::maxItems)
                ? itemMapPkg::countW'(itemMapPkg::maxItems)
                : itemMapPkg::countW'(requestSum);
            stoneLimit <= {1'b0, stoneCount};
            goldLimit <= stoneCount + goldCount;
        end
        if (state == stateDraw) begin
            candX <= itemMapPkg::posXW'(cellCol) << itemMapPkg::cellShift;
            candY <= itemMapPkg::posYW'(cellRow) << itemMapPkg::cellShift;
        end
    end

    // index is the truncated count, so the count must not have saturated
    indexInRange: assert property (
        @(posedge clock) disable iff (!resetn)
        placeEnable |-> itemCount < itemMapPkg::maxItems
    );

    // a saved cell never repeats an earlier item
    placeUnique: assert property (
        @(posedge clock) disable iff (!resetn)
        placeEnable |-> !candTaken
    );

endmodule

// ==== hw/itemRandom.sv ====
`timescale 1ns/1ns

// linear congruential generator, steps once per enabled cycle
module itemRandom (
    input  logic clock,
    input  logic resetn,
    input  logic randomEnable,
    output logic [itemMapPkg::randW-1:0] randomValue
);

    // next value, already truncated to randW bits
    logic [itemMapPkg::randW-1:0] randomNext;

    // truncation does the modulo for free
    assign randomNext = itemMapPkg::randW'(
        itemMapPkg::randMulA * randomValue + itemMapPkg::randAddB);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            randomValue <= itemMapPkg::randW'(itemMapPkg::randSeed);
        end else if (randomEnable) begin
            randomValue <= randomNext;
        end
    end

    // placer folds this straight into a cell, x here would spread
    // into every record written afterwards
    randomKnown: assert property (
        @(posedge clock) disable iff (!resetn)
        !$isunknown(randomValue)
    );

endmodule

// ==== hw/itemTable.sv ====
`timescale 1ns/1ns

// item records with clear, placement write and two move ports
module itemTable (
    input  logic clock,
    input  logic resetn,
    input  logic tableClear,
    input  logic placeEnable,
    input  logic busy,
    input  logic [itemMapPkg::indexW-1:0] placeIndex,
    input  itemMapPkg::itemRecordT placeRecord,
    input  logic moveEnableA,
    input  logic movedA,
    input  logic visibleA,
    input  logic [itemMapPkg::indexW-1:0] moveIndexA,
    input  logic signed [itemMapPkg::deltaW-1:0] deltaXA,
    input  logic signed [itemMapPkg::deltaW-1:0] deltaYA,
    input  logic moveEnableB,
    input  logic movedB,
    input  logic visibleB,
    input  logic [itemMapPkg::indexW-1:0] moveIndexB,
    input  logic signed [itemMapPkg::deltaW-1:0] deltaXB,
    input  logic signed [itemMapPkg::deltaW-1:0] deltaYB,
    output itemMapPkg::itemRecordT items [itemMapPkg::maxItems]
);

    // table with both moves folded in
    itemMapPkg::itemRecordT movedItems [itemMapPkg::maxItems];

    // port A first, then port B on top of it
    // same index gives summed deltas and B flags
    always_comb begin
        movedItems = items;
        if (moveEnableA) begin
            // size cast sign-extends the delta, sum wraps
            movedItems[moveIndexA].posX =
                movedItems[moveIndexA].posX + itemMapPkg::posXW'(deltaXA);
            movedItems[moveIndexA].posY =
                movedItems[moveIndexA].posY + itemMapPkg::posYW'(deltaYA);
            movedItems[moveIndexA].moved = movedA;
            movedItems[moveIndexA].visible = visibleA;
        end
        if (moveEnableB) begin
            movedItems[moveIndexB].posX =
                movedItems[moveIndexB].posX + itemMapPkg::posXW'(deltaXB);
            movedItems[moveIndexB].posY =
                movedItems[moveIndexB].posY + itemMapPkg::posYW'(deltaYB);
            movedItems[moveIndexB].moved = movedB;
            movedItems[moveIndexB].visible = visibleB;
        end
    end

    // clear over placement over moves
    always_ff @(posedge clock) begin
        if (!resetn || tableClear) begin
            items <= '{default: '0};
        end else if (placeEnable) begin
            items[placeIndex] <= placeRecord;
        end else if (!busy) begin
            // moves only between generations
            items <= movedItems;
        end
    end

    // a move strobe during generation leaves its record untouched
    property holdWhileBusy(logic enable, logic [itemMapPkg::indexW-1:0] index);
        @(posedge clock) disable iff (!resetn)
        busy && enable && !tableClear && !placeEnable
            |=> items[$past(index)] == $past(items[index]);
    endproperty

    noMoveWhileBusyA: assert property (holdWhileBusy(moveEnableA, moveIndexA));
    noMoveWhileBusyB: assert property (holdWhileBusy(moveEnableB, moveIndexB));

endmodule

// ==== verification/itemMapModel.svh ====
`ifndef ITEM_MAP_MODEL_SVH
`define ITEM_MAP_MODEL_SVH

// fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// one step per bit taken, lsb first
task automatic takeBits(input int width, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < width; i++) begin
        lfsrState = lfsrStep(lfsrState);
        value[i] = lfsrState[0];
    end
endtask

// total placed, capped at table size
function automatic logic [itemMapPkg::countW-1:0] refCount(
        input int stones, input int golds, input int diamonds);
    int total;
    total = stones + golds + diamonds;
    if (total > itemMapPkg::maxItems) begin
        total = itemMapPkg::maxItems;
    end
    return itemMapPkg::countW'(total);
endfunction

// stones first, then gold, then diamonds
function automatic itemMapPkg::itemKindT refKind(
        input int index, input int stones, input int golds);
    if (index < stones) begin
        return itemMapPkg::kindStone;
    end else if (index < stones + golds) begin
        return itemMapPkg::kindGold;
    end
    return itemMapPkg::kindDiamond;
endfunction

// deltas arrive already sign-extended
function automatic itemMapPkg::itemRecordT refMove(input itemMapPkg::itemRecordT record,
        input int deltaX, input int deltaY, input logic moved, input logic visible);
    itemMapPkg::itemRecordT result;
    int sumX;
    int sumY;
    result = record;
    sumX = int'(record.posX) + deltaX;
    sumY = int'(record.posY) + deltaY;
    // wrap modulo the field width
    result.posX = sumX[itemMapPkg::posXW-1:0];
    result.posY = sumY[itemMapPkg::posYW-1:0];
    result.moved = moved;
    result.visible = visible;
    return result;
endfunction

task automatic compareCount(input string name,
        input logic [itemMapPkg::countW-1:0] expected,
        input logic [itemMapPkg::countW-1:0] actual);
    checkTotal++;
    if (actual !== expected) begin
        errorCount++;
        $display("** Error: %s: expected %0d, actual %0d", name, expected, actual);
    end
endtask

task automatic compareKind(input string name,
        input itemMapPkg::itemKindT expected, input itemMapPkg::itemKindT actual);
    checkTotal++;
    if (actual !== expected) begin
        errorCount++;
        $display("** Error: %s: expected %0d, actual %0d", name, expected, actual);
    end
endtask

task automatic compareRecord(input string name,
        input itemMapPkg::itemRecordT expected, input itemMapPkg::itemRecordT actual);
    checkTotal++;
    if (actual !== expected) begin
        errorCount++;
        $display("** Error: %s: expected %h, actual %h", name, expected, actual);
    end
endtask

// failures that have no single expected value
task automatic reportFailure(input string text);
    errorCount++;
    $display("Error: %s", text);
endtask

`endif

// ==== verification/itemMapTb.sv ====
`timescale 1ns/1ns

// item map testbench: generation, cell rules and both move ports
module itemMapTb;

    localparam int timeoutCycles = 2000;

    logic clock;
    logic resetn;
    logic generateStart;
    logic [itemMapPkg::quantityW-1:0] stoneCount;
    logic [itemMapPkg::quantityW-1:0] goldCount;
    logic [itemMapPkg::quantityW-1:0] diamondCount;
    logic moveEnableA;
    logic movedA;
    logic visibleA;
    logic [itemMapPkg::indexW-1:0] moveIndexA;
    logic signed [itemMapPkg::deltaW-1:0] deltaXA;
    logic signed [itemMapPkg::deltaW-1:0] deltaYA;
    logic moveEnableB;
    logic movedB;
    logic visibleB;
    logic [itemMapPkg::indexW-1:0] moveIndexB;
    logic signed [itemMapPkg::deltaW-1:0] deltaXB;
    logic signed [itemMapPkg::deltaW-1:0] deltaYB;
    logic busy;
    logic [itemMapPkg::countW-1:0] itemCount;
    itemMapPkg::itemRecordT items [itemMapPkg::maxItems];

    int errorCount;
    int checkTotal;
    logic [31:0] lfsrState;

    // expected table, shared with the checker
    itemMapPkg::itemRecordT modelItems [itemMapPkg::maxItems];
    logic [itemMapPkg::countW-1:0] modelCount;
    int requestStones;
    int requestGolds;
    string testName;
    // set after a generation, where positions are random
    bit placementMode;
    event checkRequest;

    `include "itemMapModel.svh"

    tbClockGen #(.periodNs(10), .resetCycles(10)) tbClockGen_i (
        .clock(clock),
        .resetn(resetn)
    );

    itemMap itemMap_i (
        .clock(clock),
        .resetn(resetn),
        .generateStart(generateStart),
        .stoneCount(stoneCount),
        .goldCount(goldCount),
        .diamondCount(diamondCount),
        .moveEnableA(moveEnableA),
        .movedA(movedA),
        .visibleA(visibleA),
        .moveIndexA(moveIndexA),
        .deltaXA(deltaXA),
        .deltaYA(deltaYA),
        .moveEnableB(moveEnableB),
        .movedB(movedB),
        .visibleB(visibleB),
        .moveIndexB(moveIndexB),
        .deltaXB(deltaXB),
        .deltaYB(deltaYB),
        .busy(busy),
        .itemCount(itemCount),
        .items(items)
    );

    // kind and flags by order, cell in range, no shared position
    task automatic checkPlacement();
        itemMapPkg::itemRecordT expected;
        int col;
        int row;
        for (int i = 0; i < itemMapPkg::maxItems; i++) begin
            expected = '0;
            if (i < modelCount) begin
                expected.posX = items[i].posX;
                expected.posY = items[i].posY;
                expected.kind = refKind(i, requestStones, requestGolds);
                expected.visible = 1'b1;
                compareKind($sformatf("%s kind %0d", testName, i), expected.kind, items[i].kind);
                col = int'(items[i].posX) >> itemMapPkg::cellShift;
                row = int'(items[i].posY) >> itemMapPkg::cellShift;
                if (items[i].posX[itemMapPkg::cellShift-1:0] != 0
                        || col < 1 || col > itemMapPkg::gridCols) begin
                    reportFailure($sformatf("%s: item %0d is not on a valid column", testName, i));
                end
                if (items[i].posY[itemMapPkg::cellShift-1:0] != 0
                        || row < 1 || row > itemMapPkg::gridRows) begin
                    reportFailure($sformatf("%s: item %0d is not on a valid row", testName, i));
                end
                for (int j = 0; j < i; j++) begin
                    if (items[j].posX == items[i].posX && items[j].posY == items[i].posY) begin
                        reportFailure($sformatf("%s: items %0d and %0d share a cell",
                            testName, j, i));
                    end
                end
            end
            compareRecord($sformatf("%s record %0d", testName, i), expected, items[i]);
        end
    endtask

    // port values from the LFSR, no waiting
    task automatic driveRandomMoves(input bit enableA, input bit enableB, input bit sameIndex);
        logic [31:0] bits;
        moveEnableA = enableA;
        moveEnableB = enableB;
        takeBits(itemMapPkg::indexW, bits);
        moveIndexA = itemMapPkg::indexW'(bits);
        takeBits(3, bits);
        // a nonzero xor keeps the two ports apart
        moveIndexB = sameIndex ? moveIndexA : moveIndexA ^ itemMapPkg::indexW'(bits % 7 + 1);
        takeBits(itemMapPkg::deltaW, bits);
        deltaXA = itemMapPkg::deltaW'(bits);
        takeBits(itemMapPkg::deltaW, bits);
        deltaYA = itemMapPkg::deltaW'(bits);
        takeBits(itemMapPkg::deltaW, bits);
        deltaXB = itemMapPkg::deltaW'(bits);
        takeBits(itemMapPkg::deltaW, bits);
        deltaYB = itemMapPkg::deltaW'(bits);
        takeBits(4, bits);
        movedA = bits[0];
        visibleA = bits[1];
        movedB = bits[2];
        visibleB = bits[3];
    endtask

    task automatic requestCheck(input string name, input bit placement);
        testName = name;
        placementMode = placement;
        ->checkRequest;
    endtask

    // one move cycle, model follows port A then port B
    task automatic applyMoves(input string name, input bit enableA, input bit enableB,
            input bit sameIndex);
        driveRandomMoves(enableA, enableB, sameIndex);
        @(posedge clock);
        #1;
        if (enableA) begin
            modelItems[moveIndexA] = refMove(modelItems[moveIndexA],
                int'(deltaXA), int'(deltaYA), movedA, visibleA);
        end
        if (enableB) begin
            modelItems[moveIndexB] = refMove(modelItems[moveIndexB],
                int'(deltaXB), int'(deltaYB), movedB, visibleB);
        end
        moveEnableA = 1'b0;
        moveEnableB = 1'b0;
        requestCheck(name, 1'b0);
    endtask

    // random counts, start strobe, wait for busy to fall
    task automatic runGeneration(input string name, input bit movesWhileBusy);
        logic [31:0] bits;
        int cycles;
        takeBits(itemMapPkg::quantityW, bits);
        stoneCount = itemMapPkg::quantityW'(bits);
        takeBits(itemMapPkg::quantityW, bits);
        goldCount = itemMapPkg::quantityW'(bits);
        takeBits(itemMapPkg::quantityW, bits);
        diamondCount = itemMapPkg::quantityW'(bits);
        generateStart = 1'b1;
        @(posedge clock);
        #1;
        generateStart = 1'b0;
        if (!busy) begin
            reportFailure($sformatf("%s: busy did not rise after the start strobe", name));
        end
        cycles = 0;
        while (busy && cycles < timeoutCycles) begin
            // these strobes must be ignored
            if (movesWhileBusy) begin
                driveRandomMoves(1'b1, 1'b1, cycles[0]);
            end
            @(posedge clock);
            #1;
            cycles++;
        end
        moveEnableA = 1'b0;
        moveEnableB = 1'b0;
        if (busy) begin
            reportFailure($sformatf("%s: busy still high after %0d cycles", name, timeoutCycles));
        end
        requestStones = int'(stoneCount);
        requestGolds = int'(goldCount);
        modelCount = refCount(requestStones, requestGolds, int'(diamondCount));
        requestCheck(name, 1'b1);
    endtask

    // compares the DUT against the model on request
    initial begin
        forever begin
            @(checkRequest);
            compareCount({testName, " count"}, modelCount, itemCount);
            if (placementMode) begin
                checkPlacement();
                // later moves start from the placed table
                modelItems = items;
            end else begin
                for (int i = 0; i < itemMapPkg::maxItems; i++) begin
                    compareRecord($sformatf("%s record %0d", testName, i),
                        modelItems[i], items[i]);
                end
            end
        end
    end

    initial begin
        int cycles;
        errorCount = 0;
        checkTotal = 0;
        lfsrState = 32'h4cde_440d;
        modelItems = '{default: '0};
        modelCount = '0;
        generateStart = 1'b0;
        stoneCount = '0;
        goldCount = '0;
        diamondCount = '0;
        moveEnableA = 1'b0;
        movedA = 1'b0;
        visibleA = 1'b0;
        moveIndexA = '0;
        deltaXA = '0;
        deltaYA = '0;
        moveEnableB = 1'b0;
        movedB = 1'b0;
        visibleB = 1'b0;
        moveIndexB = '0;
        deltaXB = '0;
        deltaYB = '0;
        cycles = 0;
        // resetn may still be unknown at time zero
        while (resetn !== 1'b1 && cycles < 100) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (resetn !== 1'b1) begin
            reportFailure("reset was never released");
        end
        if (busy !== 1'b0) begin
            reportFailure("busy is not low after reset");
        end
        requestCheck("reset", 1'b0);
        runGeneration("generate", 1'b0);
        repeat (3) begin
            applyMoves("move A", 1'b1, 1'b0, 1'b0);
        end
        applyMoves("move A and B apart", 1'b1, 1'b1, 1'b0);
        applyMoves("move A and B same index", 1'b1, 1'b1, 1'b1);
        runGeneration("generate with moves while busy", 1'b1);
        applyMoves("move after regenerate", 1'b1, 1'b1, 1'b0);
        @(posedge clock);
        #1;
        $display("%0d checks, %0d errors", checkTotal, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/tbClockGen.sv ====
`timescale 1ns/1ns

// free-running clock, reset held low for a few edges
module tbClockGen #(
    parameter int periodNs = 10,
    parameter int resetCycles = 10
) (
    output logic clock,
    output logic resetn
);

    initial begin
        clock = 1'b0;
        forever begin
            #(periodNs / 2) clock = ~clock;
        end
    end

    // released on an edge, so the DUT sees low on every counted edge
    initial begin
        resetn = 1'b0;
        repeat (resetCycles) @(posedge clock);
        resetn <= 1'b1;
    end

endmodule

// ==== vlog.f ====
+incdir+verification
hw/itemMapPkg.sv
hw/itemRandom.sv
hw/itemPlacer.sv
hw/itemTable.sv
hw/itemMap.sv
verification/tbClockGen.sv
verification/itemMapTb.sv
